//--- include/rv_decode_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_XLEN        32
`define RV_REG_IDX_W   5
`define RV_CAUSE_W     4
`define RV_ALU_OP_W    19
`define RV_JMP_OP_W    9
`define RV_MEM_OP_W    9
`define RV_CSR_OP_W    6
`define RV_SYS_OP_W    8

// major opcode, instr[6:2]
`define OPC_BRANCH     5'b11000
`define OPC_JALR       5'b11001
`define OPC_JAL        5'b11011
`define OPC_AUIPC      5'b00101
`define OPC_OP_IMM     5'b00100
`define OPC_OP         5'b01100
`define OPC_LUI        5'b01101
`define OPC_LOAD       5'b00000
`define OPC_STORE      5'b01000
`define OPC_SYSTEM     5'b11100
`define OPC_CUSTOM     5'b11111

`define INSTR_ECALL    32'h0000_0073
`define INSTR_EBREAK   32'h0010_0073
`define INSTR_MRET     32'h3020_0073
`define INSTR_SRET     32'h1020_0073
`define INSTR_WFI      32'h1050_0073

`define CAUSE_ILLEGAL     4'd2
`define CAUSE_BREAKPOINT  4'd3
`define CAUSE_ECALL_M     4'd11

`endif

//--- src/rv_decode_pkg.sv
`include "rv_decode_defs.svh"

package rv_decode_pkg;

    typedef logic [`RV_XLEN-1:0]      instr_t;
    typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`RV_XLEN-1:0]      imm_t;

    // one-hot, [9:0] reg forms, [18:10] imm forms
    typedef logic [`RV_ALU_OP_W-1:0]  alu_op_t;

    // encoded code, auipc on bit 8
    typedef logic [`RV_JMP_OP_W-1:0]  jmp_op_t;

    // one-hot, lui / loads / stores
    typedef logic [`RV_MEM_OP_W-1:0]  mem_op_t;

    typedef logic [`RV_CSR_OP_W-1:0]  csr_op_t;

    // one-hot machine ops, bits 3 and 6..7 unused
    typedef logic [`RV_SYS_OP_W-1:0]  sys_op_t;

    typedef logic [`RV_CAUSE_W-1:0]   cause_t;

    typedef struct packed {
        alu_op_t  alu_op;
        jmp_op_t  jmp_op;
        mem_op_t  mem_op;
        logic     cust_op;
        csr_op_t  csr_op;
        sys_op_t  sys_op;
        logic     illegal;
        logic     trap;       // synchronous exception request
        cause_t   cause;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        imm_t     imm;
    } decode_bus_t;

endpackage

//--- src/instruction_decode.sv
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module instruction_decode (
    input  rv_decode_pkg::instr_t   instr,
    output rv_decode_pkg::alu_op_t  alu_op,
    output rv_decode_pkg::jmp_op_t  jmp_op,
    output rv_decode_pkg::mem_op_t  mem_op,
    output logic                    cust_op,
    output rv_decode_pkg::csr_op_t  csr_op,
    output rv_decode_pkg::sys_op_t  sys_op,
    output logic                    illegal,
    output rv_decode_pkg::reg_idx_t rd,
    output rv_decode_pkg::reg_idx_t rs1,
    output rv_decode_pkg::reg_idx_t rs2
);

    logic [4:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr[6:2];
    assign funct3 = instr[14:12];

    // register fields pass through raw, even when unused
    assign rd  = instr[11:7];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    always_comb begin
        alu_op  = '0;
        jmp_op  = '0;
        mem_op  = '0;
        cust_op = 1'b0;
        csr_op  = '0;
        sys_op  = '0;
        illegal = 1'b0;

        // groups stay zero on every illegal path
        if (instr[1:0] != 2'b11) begin
            illegal = 1'b1;                                 // compressed / reserved
        end else begin
            case (opcode)
                `OPC_BRANCH: begin
                    case (funct3)
                        3'b000:  jmp_op = 9'd0;             // beq
                        3'b001:  jmp_op = 9'd1;             // bne
                        3'b100:  jmp_op = 9'd2;             // blt
                        3'b101:  jmp_op = 9'd3;             // bge
                        3'b110:  jmp_op = 9'd4;             // bltu
                        3'b111:  jmp_op = 9'd5;             // bgeu
                        default: illegal = 1'b1;
                    endcase
                end
                `OPC_JALR: begin
                    if (funct3 == 3'b000) begin
                        jmp_op = 9'd6;
                    end else begin
                        illegal = 1'b1;
                    end
                end
                `OPC_JAL:   jmp_op = 9'd1;                  // shares the bne code
                `OPC_AUIPC: jmp_op = 9'b1_0000_0000;
                `OPC_OP: begin
                    case (funct3)
                        3'b000:  alu_op[instr[30] ? 1 : 0] = 1'b1;   // add/sub
                        3'b001:  alu_op[2] = 1'b1;          // sll
                        3'b010:  alu_op[3] = 1'b1;          // slt
                        3'b011:  alu_op[4] = 1'b1;          // sltu
                        3'b100:  alu_op[5] = 1'b1;          // xor
                        3'b101:  alu_op[instr[30] ? 7 : 6] = 1'b1;   // srl/sra
                        3'b110:  alu_op[8] = 1'b1;          // or
                        default: alu_op[9] = 1'b1;          // and
                    endcase
                end
                `OPC_OP_IMM: begin
                    case (funct3)
                        3'b000:  alu_op[10] = 1'b1;         // addi
                        3'b001:  alu_op[11] = 1'b1;         // slli
                        3'b010:  alu_op[12] = 1'b1;         // slti
                        3'b011:  alu_op[13] = 1'b1;         // sltiu
                        3'b100:  alu_op[14] = 1'b1;         // xori
                        3'b101:  alu_op[instr[30] ? 16 : 15] = 1'b1; // srli/srai
                        3'b110:  alu_op[17] = 1'b1;         // ori
                        default: alu_op[18] = 1'b1;         // andi
                    endcase
                end
                `OPC_LUI: mem_op[0] = 1'b1;
                `OPC_LOAD: begin
                    case (funct3)
                        3'b000:  mem_op[1] = 1'b1;          // lb
                        3'b001:  mem_op[2] = 1'b1;          // lh
                        3'b010:  mem_op[3] = 1'b1;          // lw
                        3'b100:  mem_op[4] = 1'b1;          // lbu
                        3'b101:  mem_op[5] = 1'b1;          // lhu
                        default: illegal = 1'b1;
                    endcase
                end
                `OPC_STORE: begin
                    case (funct3)
                        3'b000:  mem_op[6] = 1'b1;          // sb
                        3'b001:  mem_op[7] = 1'b1;          // sh
                        3'b010:  mem_op[8] = 1'b1;          // sw
                        default: illegal = 1'b1;
                    endcase
                end
                `OPC_SYSTEM: begin
                    if (funct3 == 3'b000) begin
                        // priv ops must match the whole word
                        case (instr)
                            `INSTR_EBREAK: sys_op[0] = 1'b1;
                            `INSTR_ECALL:  sys_op[1] = 1'b1;
                            `INSTR_MRET:   sys_op[2] = 1'b1;
                            `INSTR_SRET:   sys_op[4] = 1'b1;
                            `INSTR_WFI:    sys_op[5] = 1'b1;
                            default:       illegal = 1'b1;
                        endcase
                    end else begin
                        case (funct3)
                            3'b001:  csr_op[0] = 1'b1;      // csrrw
                            3'b010:  csr_op[1] = 1'b1;      // csrrs
                            3'b011:  csr_op[2] = 1'b1;      // csrrc
                            3'b101:  csr_op[3] = 1'b1;      // csrrwi
                            3'b110:  csr_op[4] = 1'b1;      // csrrsi
                            3'b111:  csr_op[5] = 1'b1;      // csrrci
                            default: illegal = 1'b1;        // funct3 100
                        endcase
                    end
                end
                `OPC_CUSTOM: cust_op = 1'b1;
                default:     illegal = 1'b1;
            endcase
        end
    end

endmodule

//--- src/imm_gen.sv
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module imm_gen (
    input  rv_decode_pkg::instr_t instr,
    output rv_decode_pkg::imm_t   imm
);

    logic [4:0] opcode;
    logic       sign;

    assign opcode = instr[6:2];
    assign sign   = instr[31];

    always_comb begin
        case (opcode)
            `OPC_OP_IMM, `OPC_LOAD, `OPC_JALR: begin
                imm = {{20{sign}}, instr[31:20]};                      // I
            end
            `OPC_STORE: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};         // S
            end
            `OPC_BRANCH: begin
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};                             // B
            end
            `OPC_LUI, `OPC_AUIPC: begin
                imm = {instr[31:12], 12'b0};                           // U
            end
            `OPC_JAL: begin
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};                            // J
            end
            default: imm = '0;                                         // no immediate
        endcase
    end

endmodule

//--- src/trap_cause.sv
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module trap_cause (
    input  logic                   illegal,
    input  rv_decode_pkg::sys_op_t sys_op,
    output logic                   trap,
    output rv_decode_pkg::cause_t  cause
);

    // illegal beats ecall beats ebreak
    always_comb begin
        trap = 1'b1;
        if (illegal) begin
            cause = `CAUSE_ILLEGAL;
        end else if (sys_op[1]) begin
            cause = `CAUSE_ECALL_M;        // ecall from M mode
        end else if (sys_op[0]) begin
            cause = `CAUSE_BREAKPOINT;     // ebreak
        end else begin
            trap  = 1'b0;
            cause = '0;
        end
    end

endmodule

//--- src/decode_pipe_reg.sv
`timescale 1ns/1ps

module decode_pipe_reg (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       in_valid,
    input  rv_decode_pkg::decode_bus_t in_bus,
    output logic                       out_valid,
    output rv_decode_pkg::decode_bus_t out_bus
);

    logic load;

    assign load = in_valid & ~flush;    // flush wins over valid

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= load;
        end
    end

    // bundle holds its last value when nothing loads
    always_ff @(posedge clk) begin
        if (reset) begin
            out_bus <= '0;
        end else if (load) begin
            out_bus <= in_bus;
        end
    end

endmodule

//--- src/rv_decode_top.sv
`timescale 1ns/1ps

module rv_decode_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       instr_valid,
    input  rv_decode_pkg::instr_t      instr,
    input  logic                       flush,
    output logic                       dec_valid,
    output rv_decode_pkg::decode_bus_t dec
);

    rv_decode_pkg::decode_bus_t bus;

    instruction_decode i_instruction_decode (
        .instr   (instr),
        .alu_op  (bus.alu_op),
        .jmp_op  (bus.jmp_op),
        .mem_op  (bus.mem_op),
        .cust_op (bus.cust_op),
        .csr_op  (bus.csr_op),
        .sys_op  (bus.sys_op),
        .illegal (bus.illegal),
        .rd      (bus.rd),
        .rs1     (bus.rs1),
        .rs2     (bus.rs2)
    );

    imm_gen i_imm_gen (
        .instr (instr),
        .imm   (bus.imm)
    );

    trap_cause i_trap_cause (
        .illegal (bus.illegal),
        .sys_op  (bus.sys_op),
        .trap    (bus.trap),
        .cause   (bus.cause)
    );

    decode_pipe_reg i_decode_pipe_reg (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (instr_valid),
        .in_bus    (bus),
        .out_valid (dec_valid),
        .out_bus   (dec)
    );

endmodule

//--- tests/tb_rv_decode_top.sv
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module tb_rv_decode_top;

    localparam int clk_period  = 40;
    localparam int stream_len  = 300;
    localparam int stim_cycles = 150 + 100 + 2 * stream_len + 20;  // directed, imm, stream

    localparam logic [4:0] opc_list [11] = '{`OPC_BRANCH, `OPC_JALR, `OPC_JAL, `OPC_AUIPC,
        `OPC_OP_IMM, `OPC_OP, `OPC_LUI, `OPC_LOAD, `OPC_STORE, `OPC_SYSTEM, `OPC_CUSTOM};
    localparam rv_decode_pkg::instr_t sys_words [5] = '{`INSTR_ECALL, `INSTR_EBREAK,
        `INSTR_MRET, `INSTR_SRET, `INSTR_WFI};

    logic                       clk;
    logic                       reset;
    logic                       instr_valid;
    logic                       flush;
    rv_decode_pkg::instr_t      instr;
    logic                       dec_valid;
    rv_decode_pkg::decode_bus_t dec;

    integer                     seed = 32'h5798_1a6b;
    int                         errors = 0;
    int                         checks = 0;
    logic                       valid_q[$];
    rv_decode_pkg::decode_bus_t bus_q[$];
    rv_decode_pkg::decode_bus_t last_exp;

    rv_decode_top i_rv_decode_top (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .flush       (flush),
        .dec_valid   (dec_valid),
        .dec         (dec)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic rv_decode_pkg::decode_bus_t ref_decode(rv_decode_pkg::instr_t w);
        rv_decode_pkg::decode_bus_t b;
        logic [4:0]         opc;
        int                 fn;
        int                 pos;
        logic signed [11:0] i_imm;
        logic signed [11:0] s_imm;
        logic signed [12:0] b_imm;
        logic signed [20:0] j_imm;
        b     = '0;
        opc   = w[6:2];
        fn    = int'(w[14:12]);
        i_imm = w[31:20];
        s_imm = {w[31:25], w[11:7]};
        b_imm = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        j_imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        b.rd  = w[11:7];
        b.rs1 = w[19:15];
        b.rs2 = w[24:20];
        case (opc)
            `OPC_OP_IMM, `OPC_LOAD, `OPC_JALR: b.imm = 32'(i_imm);
            `OPC_STORE:            b.imm = 32'(s_imm);
            `OPC_BRANCH:           b.imm = 32'(b_imm);
            `OPC_LUI, `OPC_AUIPC:  b.imm = {w[31:12], 12'h000};
            `OPC_JAL:              b.imm = 32'(j_imm);
            default:               b.imm = '0;
        endcase
        if (w[1:0] != 2'b11) begin
            b.illegal = 1'b1;
        end else begin
            case (opc)
                `OPC_BRANCH: b.illegal = (fn == 2) || (fn == 3);
                `OPC_LOAD:   b.illegal = (fn == 3) || (fn >= 6);
                `OPC_STORE:  b.illegal = (fn > 2);
                `OPC_JALR:   b.illegal = (fn != 0);
                `OPC_SYSTEM: b.illegal = (fn == 4) || (fn == 0 && !(w inside {`INSTR_ECALL,
                    `INSTR_EBREAK, `INSTR_MRET, `INSTR_SRET, `INSTR_WFI}));
                `OPC_JAL, `OPC_AUIPC, `OPC_OP_IMM, `OPC_OP, `OPC_LUI, `OPC_CUSTOM:
                    b.illegal = 1'b0;
                default:     b.illegal = 1'b1;
            endcase
        end
        if (!b.illegal) begin
            case (opc)
                `OPC_OP: begin
                    pos = fn + int'(fn != 0) + int'(fn >= 6) + int'(w[30] && (fn == 0 || fn == 5));
                    b.alu_op[pos] = 1'b1;
                end
                `OPC_OP_IMM: begin
                    pos = 10 + fn + int'(fn >= 6) + int'(w[30] && fn == 5);
                    b.alu_op[pos] = 1'b1;
                end
                `OPC_BRANCH: b.jmp_op = 9'((fn < 4) ? fn : fn - 2);
                `OPC_JALR:   b.jmp_op = 9'd6;
                `OPC_JAL:    b.jmp_op = 9'd1;           // same code as bne
                `OPC_AUIPC:  b.jmp_op = 9'h100;
                `OPC_LUI:    b.mem_op[0] = 1'b1;
                `OPC_LOAD:   b.mem_op[(fn < 3) ? fn + 1 : fn] = 1'b1;
                `OPC_STORE:  b.mem_op[6 + fn] = 1'b1;
                `OPC_SYSTEM: begin
                    if (fn != 0) begin
                        b.csr_op[(fn < 4) ? fn - 1 : fn - 2] = 1'b1;
                    end else begin
                        b.sys_op[0] = (w == `INSTR_EBREAK);
                        b.sys_op[1] = (w == `INSTR_ECALL);
                        b.sys_op[2] = (w == `INSTR_MRET);
                        b.sys_op[4] = (w == `INSTR_SRET);
                        b.sys_op[5] = (w == `INSTR_WFI);
                    end
                end
                default:     b.cust_op = 1'b1;          // only custom is left
            endcase
        end
        b.trap = 1'b1;
        if (b.illegal) begin
            b.cause = `CAUSE_ILLEGAL;
        end else if (w == `INSTR_ECALL) begin
            b.cause = `CAUSE_ECALL_M;
        end else if (w == `INSTR_EBREAK) begin
            b.cause = `CAUSE_BREAKPOINT;
        end else begin
            b.trap = 1'b0;
        end
        return b;
    endfunction

    function automatic rv_decode_pkg::instr_t shape(rv_decode_pkg::instr_t w, logic [4:0] opc,
                                                    logic [2:0] f3);
        return {w[31:15], f3, w[11:7], opc, 2'b11};
    endfunction

    task automatic rand_word(output rv_decode_pkg::instr_t w);
        w = $random(seed);
    endtask

    task automatic show_field(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: dec.%s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_valid(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: dec_valid got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic compare_bus(input rv_decode_pkg::decode_bus_t got,
                               input rv_decode_pkg::decode_bus_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            show_field("alu_op", 32'(got.alu_op), 32'(exp.alu_op));
            show_field("jmp_op", 32'(got.jmp_op), 32'(exp.jmp_op));
            show_field("mem_op", 32'(got.mem_op), 32'(exp.mem_op));
            show_field("cust_op", 32'(got.cust_op), 32'(exp.cust_op));
            show_field("csr_op", 32'(got.csr_op), 32'(exp.csr_op));
            show_field("sys_op", 32'(got.sys_op), 32'(exp.sys_op));
            show_field("illegal", 32'(got.illegal), 32'(exp.illegal));
            show_field("trap", 32'(got.trap), 32'(exp.trap));
            show_field("cause", 32'(got.cause), 32'(exp.cause));
            show_field("rd", 32'(got.rd), 32'(exp.rd));
            show_field("rs1", 32'(got.rs1), 32'(exp.rs1));
            show_field("rs2", 32'(got.rs2), 32'(exp.rs2));
            show_field("imm", got.imm, exp.imm);
        end
    endtask

    // called 2 ns after an edge, returns 2 ns after the next one
    task automatic drive(input logic v, input logic f, input rv_decode_pkg::instr_t w);
        instr_valid = v;
        flush       = f;
        instr       = w;
        valid_q.push_back(v & ~f);
        if (v && !f) begin
            last_exp = ref_decode(w);
        end
        bus_q.push_back(last_exp);                      // dec holds otherwise
        @(posedge clk);
        #2;
    endtask

    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (valid_q.size() > 0) begin
                compare_valid(dec_valid, valid_q.pop_front());
                compare_bus(dec, bus_q.pop_front());
            end
        end
    end

    initial begin
        #((stim_cycles + 50) * clk_period);
        $display("timeout: stimulus did not finish within %0d cycles", stim_cycles + 50);
        $display("tests failed");
        $finish;
    end

    initial begin
        rv_decode_pkg::instr_t w;
        logic [31:0]           r;
        instr_valid = 1'b0;
        flush       = 1'b0;
        instr       = '0;
        reset       = 1'b1;
        last_exp    = '0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        compare_valid(dec_valid, 1'b0);
        compare_bus(dec, '0);
        repeat (3) begin
            rand_word(w);
            drive(1'b0, 1'b0, w);                       // stays low until first valid
        end

        for (int f = 0; f < 16; f++) begin              // every funct3, bit 30 both ways
            rand_word(w);
            w[30] = f[3];
            drive(1'b1, 1'b0, shape(w, `OPC_OP, f[2:0]));
            drive(1'b1, 1'b0, shape(w, `OPC_OP_IMM, f[2:0]));
        end
        for (int f = 0; f < 8; f++) begin
            rand_word(w);
            drive(1'b1, 1'b0, shape(w, `OPC_BRANCH, f[2:0]));
            drive(1'b1, 1'b0, shape(w, `OPC_LOAD, f[2:0]));
            drive(1'b1, 1'b0, shape(w, `OPC_STORE, f[2:0]));
            drive(1'b1, 1'b0, shape(w, `OPC_JALR, f[2:0]));
            drive(1'b1, 1'b0, shape(w, `OPC_SYSTEM, f[2:0]));
            drive(1'b1, 1'b0, shape(w, `OPC_JAL, f[2:0]));
            drive(1'b1, 1'b0, shape(w, `OPC_AUIPC, f[2:0]));
            drive(1'b1, 1'b0, shape(w, `OPC_LUI, f[2:0]));
            drive(1'b1, 1'b0, shape(w, `OPC_CUSTOM, f[2:0]));
        end
        for (int k = 0; k < 3; k++) begin               // low bits not 11
            rand_word(w);
            w[1:0] = k[1:0];
            drive(1'b1, 1'b0, w);
        end
        for (int k = 0; k < 32; k++) begin              // whole opcode space
            rand_word(w);
            drive(1'b1, 1'b0, shape(w, k[4:0], w[14:12]));
        end
        for (int k = 0; k < 5; k++) begin
            drive(1'b1, 1'b0, sys_words[k]);
        end
        drive(1'b1, 1'b0, 32'h0020_0073);               // unknown system words
        drive(1'b1, 1'b0, 32'h7b20_0073);
        drive(1'b1, 1'b0, 32'h1200_0073);

        for (int k = 0; k < 20; k++) begin              // immediates per format
            rand_word(w);
            drive(1'b1, 1'b0, shape(w, `OPC_OP_IMM, w[14:12]));
            drive(1'b1, 1'b0, shape(w, `OPC_STORE, w[14:12]));
            drive(1'b1, 1'b0, shape(w, `OPC_BRANCH, w[14:12]));
            drive(1'b1, 1'b0, shape(w, `OPC_LUI, w[14:12]));
            drive(1'b1, 1'b0, shape(w, `OPC_JAL, w[14:12]));
        end

        for (int n = 0; n < stream_len; n++) begin
            r = $random(seed);
            rand_word(w);
            if (r[1:0] != 2'b00) begin
                w = shape(w, opc_list[int'(r[7:4]) % 11], w[14:12]);
            end
            if (r[10:8] == 3'b000) begin
                w = sys_words[int'(r[13:11]) % 5];
            end
            if (r[3:2] == 2'b00) begin
                drive(1'b0, r[20], w);                  // gap, sometimes flushed too
            end
            drive(1'b1, r[16:14] == 3'b000, w);
        end

        repeat (2) drive(1'b0, 1'b0, '0);
        while (valid_q.size() > 0) @(posedge clk);
        #2;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
src/rv_decode_pkg.sv
src/instruction_decode.sv
src/imm_gen.sv
src/trap_cause.sv
src/decode_pipe_reg.sv
src/rv_decode_top.sv
tests/tb_rv_decode_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_decode_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
